// ==== src/udp_pkg.sv ====
// Frame formats for the UDP echo core.
// Header and payload beat layouts are shared by the RTL and the testbench.

package udp_pkg;

    // IP and UDP fields of one frame, used for both received and reply headers
    typedef struct packed {
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] checksum;
    } udp_hdr_t;

    // One payload byte on the stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;   // end of frame
        logic       user;   // frame error flag from upstream
    } axis_beat_t;

    // Filter frame state
    typedef enum logic [1:0] {
        FLT_IDLE = 2'd0,
        FLT_PASS = 2'd1,
        FLT_DROP = 2'd2
    } filter_state_t;

endpackage

// ==== src/echo_cfg_pkg.sv ====
// Local configuration of the echo service.
// Address, echoed port, reply TTL and payload FIFO depth.

package echo_cfg_pkg;

    // 192.168.0.128
    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd0, 8'd128};

    // Only this destination port is echoed
    localparam logic [15:0] ECHO_PORT = 16'd1234;

    localparam logic [7:0] REPLY_TTL = 8'd64;

    // 16 entries
    localparam int FIFO_ADDR_WIDTH = 4;

endpackage

// ==== src/udp_echo_filter.sv ====
// Echo port filter. Matches the destination port of each header,
// forwards a reply header for matching frames and routes their payload
// to the FIFO; other frames are consumed and dropped.

`timescale 1ns/1ps

module udp_echo_filter
    import udp_pkg::*;
    import echo_cfg_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    // Received header
    input  logic          in_hdr_valid,
    output logic          in_hdr_ready,
    input  udp_hdr_t      in_hdr,

    // Reply header
    output logic          out_hdr_valid,
    input  logic          out_hdr_ready,
    output udp_hdr_t      out_hdr,

    // Received payload
    input  logic          in_valid,
    output logic          in_ready,
    input  axis_beat_t    in_beat,

    // FIFO write side
    output logic          fifo_valid,
    input  logic          fifo_ready,
    output axis_beat_t    fifo_beat
);

    filter_state_t state;
    logic          port_match;
    logic          hdr_fire;
    logic          end_fire;

    assign port_match = in_hdr.dest_port == ECHO_PORT;

    // Header side is only open between frames
    assign in_hdr_ready  = (state == FLT_IDLE) && (port_match ? out_hdr_ready : 1'b1);
    assign out_hdr_valid = (state == FLT_IDLE) && in_hdr_valid && port_match;
    assign hdr_fire      = in_hdr_valid && in_hdr_ready;

    // Reply header, ports swapped and sent back to the sender
    always_comb begin
        out_hdr             = '0;
        out_hdr.source_ip   = LOCAL_IP;
        out_hdr.dest_ip     = in_hdr.source_ip;
        out_hdr.source_port = in_hdr.dest_port;
        out_hdr.dest_port   = in_hdr.source_port;
        out_hdr.length      = in_hdr.length;
        out_hdr.ttl         = REPLY_TTL;
    end

    // Payload routing
    always_comb begin
        case (state)
            FLT_PASS: in_ready = fifo_ready;
            FLT_DROP: in_ready = 1'b1;
            default:  in_ready = 1'b0;
        endcase
    end

    assign fifo_valid = (state == FLT_PASS) && in_valid;
    assign fifo_beat  = in_beat;
    assign end_fire   = in_valid && in_ready && in_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FLT_IDLE;
        end else begin
            case (state)
                FLT_IDLE: begin
                    if (hdr_fire) begin
                        state <= port_match ? FLT_PASS : FLT_DROP;
                    end
                end
                FLT_PASS, FLT_DROP: begin
                    if (end_fire) begin
                        state <= FLT_IDLE;
                    end
                end
                default: state <= FLT_IDLE;
            endcase
        end
    end

endmodule

// ==== src/payload_fifo.sv ====
// Synchronous payload FIFO for byte beats with last and user flags.
// The output stage is a register; it counts towards the depth, so the
// FIFO holds 2**ADDR_WIDTH beats in total with one cycle of latency.

`timescale 1ns/1ps

module payload_fifo
    import udp_pkg::*;
    import echo_cfg_pkg::*;
#(
    parameter int ADDR_WIDTH = FIFO_ADDR_WIDTH
) (
    input  logic       clk,
    input  logic       rst,

    input  logic       wr_valid,
    output logic       wr_ready,
    input  axis_beat_t wr_beat,

    output logic       rd_valid,
    input  logic       rd_ready,
    output axis_beat_t rd_beat
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    axis_beat_t            mem [DEPTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH:0]   count;

    logic full;
    logic mem_empty;
    logic wr_fire;
    logic rd_fire;
    logic load;
    logic bypass;
    logic push_mem;
    logic pop_mem;

    // Output register empty implies memory empty, so pointers never wrap onto each other
    assign full      = count == DEPTH[ADDR_WIDTH:0];
    assign mem_empty = wr_ptr == rd_ptr;

    assign wr_ready = !full;
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    // Output stage can take a new beat
    assign load     = !rd_valid || rd_ready;
    assign pop_mem  = load && !mem_empty;
    // Straight into the output stage when nothing is queued ahead
    assign bypass   = load && mem_empty && wr_fire;
    assign push_mem = wr_fire && !bypass;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (push_mem) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_mem) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (load) begin
                rd_valid <= !mem_empty || wr_fire;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_mem) begin
            mem[wr_ptr] <= wr_beat;
        end
        if (pop_mem) begin
            rd_beat <= mem[rd_ptr];
        end else if (bypass) begin
            rd_beat <= wr_beat;
        end
    end

endmodule

// ==== src/payload_led_latch.sv ====
// Shows the first payload byte of each outgoing frame on the LEDs.
// Watches the output payload channel without driving it.

`timescale 1ns/1ps

module payload_led_latch
    import udp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       valid,
    input  logic       ready,
    input  axis_beat_t beat,
    output logic [7:0] led
);

    logic mid_frame;
    logic fire;

    assign fire = valid && ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            led       <= 8'd0;
            mid_frame <= 1'b0;
        end else if (fire) begin
            // First beat of a frame
            if (!mid_frame) begin
                led <= beat.data;
            end
            mid_frame <= !beat.last;
        end
    end

endmodule

// ==== src/udp_echo_core.sv ====
// UDP echo core. Takes parsed UDP headers and payload, returns frames sent
// to the echo port with a reply header, drops everything else.
// Chain is filter, payload FIFO, with the LED latch on the output stream.

`timescale 1ns/1ps

module udp_echo_core
    import udp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Parsed UDP input
    input  logic       in_hdr_valid,
    output logic       in_hdr_ready,
    input  udp_hdr_t   in_hdr,
    input  logic       in_valid,
    output logic       in_ready,
    input  axis_beat_t in_beat,

    // Reply output
    output logic       out_hdr_valid,
    input  logic       out_hdr_ready,
    output udp_hdr_t   out_hdr,
    output logic       out_valid,
    input  logic       out_ready,
    output axis_beat_t out_beat,

    output logic [7:0] led
);

    // Filter to FIFO write side
    logic       fifo_wr_valid;
    logic       fifo_wr_ready;
    axis_beat_t fifo_wr_beat;

    udp_echo_filter filter_inst (
        .clk           (clk),
        .rst           (rst),
        .in_hdr_valid  (in_hdr_valid),
        .in_hdr_ready  (in_hdr_ready),
        .in_hdr        (in_hdr),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_hdr       (out_hdr),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_beat       (in_beat),
        .fifo_valid    (fifo_wr_valid),
        .fifo_ready    (fifo_wr_ready),
        .fifo_beat     (fifo_wr_beat)
    );

    payload_fifo fifo_inst (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (fifo_wr_valid),
        .wr_ready (fifo_wr_ready),
        .wr_beat  (fifo_wr_beat),
        .rd_valid (out_valid),
        .rd_ready (out_ready),
        .rd_beat  (out_beat)
    );

    payload_led_latch led_inst (
        .clk   (clk),
        .rst   (rst),
        .valid (out_valid),
        .ready (out_ready),
        .beat  (out_beat),
        .led   (led)
    );

endmodule

// ==== tests/udp_echo_assert.sv ====
// Protocol checks for the UDP echo core, bound into the top level.
// Output channels hold still under back-pressure, and the filter state gates payload.

`timescale 1ns/1ps

module udp_echo_assert
    import udp_pkg::*;
    import echo_cfg_pkg::*;
(
    input logic          clk,
    input logic          rst,
    input logic          out_hdr_valid,
    input logic          out_hdr_ready,
    input udp_hdr_t      out_hdr,
    input logic          out_valid,
    input logic          out_ready,
    input axis_beat_t    out_beat,
    input logic          in_valid,
    input logic          in_ready,
    input filter_state_t flt_state
);

    hdr_stable: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> $stable(out_hdr))
        else $error("reply header changed while stalled");

    beat_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat changed or dropped while stalled");

    // Payload only moves once a header has been taken
    no_idle_payload: assert property (@(posedge clk) disable iff (rst)
        !(flt_state == FLT_IDLE && in_valid && in_ready))
        else $error("payload transfer while the filter is idle");

    reply_port: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && out_hdr_ready |-> out_hdr.source_port == ECHO_PORT)
        else $error("reply header source port is not the echo port");

endmodule

bind udp_echo_core udp_echo_assert assert_inst (
    .clk           (clk),
    .rst           (rst),
    .out_hdr_valid (out_hdr_valid),
    .out_hdr_ready (out_hdr_ready),
    .out_hdr       (out_hdr),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_beat      (out_beat),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .flt_state     (filter_inst.state)
);

// ==== tests/tb_udp_echo_core.sv ====
// Directed testbench for the UDP echo core.
// Sends frames to the echo port and to other ports; a monitor compares the
// output channels with a scoreboard built from the reply header rules.

`timescale 1ns/1ps

module tb_udp_echo_core
    import udp_pkg::*;
    import echo_cfg_pkg::*;
();

    localparam int TIMEOUT = 2000;

    logic       clk;
    logic       rst;
    logic       in_hdr_valid;
    logic       in_hdr_ready;
    udp_hdr_t   in_hdr;
    logic       in_valid;
    logic       in_ready;
    axis_beat_t in_beat;
    logic       out_hdr_valid;
    logic       out_hdr_ready;
    udp_hdr_t   out_hdr;
    logic       out_valid;
    logic       out_ready;
    axis_beat_t out_beat;
    logic [7:0] led;

    udp_hdr_t    exp_hdr[$];
    axis_beat_t  exp_beat[$];
    udp_hdr_t    mon_hdr;
    axis_beat_t  mon_beat;
    logic [31:0] data_lfsr;
    logic [31:0] gap_lfsr;
    logic        sink_enable;
    logic        sink_random;
    logic [7:0]  last_echo_byte;
    string       cur_test;

    udp_echo_core uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic value_error(input string what,
                               input logic [$bits(udp_hdr_t)-1:0] expected,
                               input logic [$bits(udp_hdr_t)-1:0] actual);
        fail_stop($sformatf("ERROR [%s] %s: expected %0h, actual %0h",
                            cur_test, what, expected, actual));
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic take_bit(inout logic [31:0] state);
        state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
        return state[0];
    endfunction

    function automatic udp_hdr_t make_hdr(input logic [15:0] dport, input int n);
        udp_hdr_t h;
        h.source_ip   = 32'hc0a8_0005;
        h.dest_ip     = LOCAL_IP;
        h.source_port = 16'd5000 + 16'(n);
        h.dest_port   = dport;
        h.length      = 16'(8 + n);
        h.ttl         = 8'd17;
        h.dscp        = 6'h2a;
        h.ecn         = 2'b01;
        h.checksum    = 16'hbeef;
        return h;
    endfunction

    // Expected reply with ports swapped, fixed TTL and zero checksum
    function automatic udp_hdr_t reply_of(input udp_hdr_t h);
        udp_hdr_t r;
        r             = '0;
        r.source_ip   = LOCAL_IP;
        r.dest_ip     = h.source_ip;
        r.source_port = h.dest_port;
        r.dest_port   = h.source_port;
        r.length      = h.length;
        r.ttl         = 8'd64;
        return r;
    endfunction

    function automatic void make_payload(input int n, output axis_beat_t beats[$]);
        axis_beat_t b;
        beats = {};
        for (int i = 0; i < n; i++) begin
            b = '0;
            for (int k = 0; k < 8; k++) begin
                b.data = {b.data[6:0], take_bit(data_lfsr)};
            end
            b.user = take_bit(data_lfsr);
            b.last = (i == n - 1);
            beats.push_back(b);
        end
    endfunction

    task automatic send_header(input udp_hdr_t h);
        int waited;
        in_hdr       <= h;
        in_hdr_valid <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) fail_stop("Timed out waiting for the DUT to take a header");
        end while (!in_hdr_ready);
        in_hdr_valid <= 1'b0;
    endtask

    task automatic push_beat(input axis_beat_t b, input int limit, output bit accepted);
        int waited;
        in_beat  <= b;
        in_valid <= 1'b1;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < limit) begin
            @(posedge clk);
            waited++;
            accepted = in_ready;
        end
    endtask

    task automatic send_payload(input axis_beat_t beats[$]);
        bit ok;
        foreach (beats[i]) begin
            push_beat(beats[i], TIMEOUT, ok);
            assert (ok) else fail_stop("Timed out waiting for the DUT to take a payload byte");
        end
        in_valid <= 1'b0;
    endtask

    task automatic send_frame(input udp_hdr_t h, input int n);
        axis_beat_t beats[$];
        make_payload(n, beats);
        if (h.dest_port == ECHO_PORT) begin
            exp_hdr.push_back(reply_of(h));
            foreach (beats[i]) exp_beat.push_back(beats[i]);
            last_echo_byte = beats[0].data;
        end
        send_header(h);
        send_payload(beats);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_hdr.size() != 0 || exp_beat.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) fail_stop("Timed out waiting for the echoed frames to come out");
        end
        repeat (2) @(posedge clk);
    endtask

    // Output sink with optional random gaps in out_ready
    always @(posedge clk) begin
        if (rst || !sink_enable) begin
            out_ready <= 1'b0;
        end else if (sink_random) begin
            out_ready <= take_bit(gap_lfsr);
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Scoreboard monitor
    always @(posedge clk) begin
        if (!rst && out_hdr_valid && out_hdr_ready) begin
            assert (exp_hdr.size() != 0)
                else fail_stop($sformatf("[%s] Reply header sent when none was expected", cur_test));
            if (exp_hdr.size() != 0) begin
                mon_hdr = exp_hdr.pop_front();
                assert (out_hdr == mon_hdr) else value_error("out_hdr", mon_hdr, out_hdr);
            end
        end
        if (!rst && out_valid && out_ready) begin
            assert (exp_beat.size() != 0)
                else fail_stop($sformatf("[%s] Payload byte sent when none was expected", cur_test));
            if (exp_beat.size() != 0) begin
                mon_beat = exp_beat.pop_front();
                assert (out_beat == mon_beat) else value_error("out_beat", mon_beat, out_beat);
            end
        end
    end

    task automatic test_after_reset();
        cur_test = "after_reset";
        assert (led == 8'd0) else value_error("led", 0, led);
        assert (out_valid == 1'b0) else value_error("out_valid", 0, out_valid);
        assert (out_hdr_valid == 1'b0) else value_error("out_hdr_valid", 0, out_hdr_valid);
        assert (in_ready == 1'b0) else value_error("in_ready", 0, in_ready);
        assert (in_hdr_ready == 1'b1) else value_error("in_hdr_ready", 1, in_hdr_ready);
    endtask

    // Holds the reply header back for a few cycles, then releases it
    task automatic stall_reply_header();
        repeat (4) @(posedge clk);
        assert (out_hdr_valid == 1'b1)
            else value_error("out_hdr_valid while stalled", 1, out_hdr_valid);
        assert (in_hdr_ready == 1'b0)
            else value_error("in_hdr_ready while stalled", 0, in_hdr_ready);
        out_hdr_ready <= 1'b1;
    endtask

    task automatic test_single_echo();
        cur_test = "single_echo";
        out_hdr_ready <= 1'b0;
        fork
            send_frame(make_hdr(ECHO_PORT, 7), 7);
            stall_reply_header();
        join
        wait_drained();
    endtask

    task automatic test_drop();
        cur_test = "drop";
        send_frame(make_hdr(16'd80, 5), 5);
        repeat (8) @(posedge clk);
        send_frame(make_hdr(ECHO_PORT, 4), 4);
        wait_drained();
    endtask

    task automatic test_back_pressure();
        udp_hdr_t   h;
        axis_beat_t beats[$];
        bit         ok;
        cur_test = "back_pressure";
        sink_enable <= 1'b0;
        repeat (2) @(posedge clk);
        h = make_hdr(ECHO_PORT, 20);
        make_payload(20, beats);
        exp_hdr.push_back(reply_of(h));
        foreach (beats[i]) exp_beat.push_back(beats[i]);
        last_echo_byte = beats[0].data;
        send_header(h);
        for (int i = 0; i < 16; i++) begin
            push_beat(beats[i], TIMEOUT, ok);
            assert (ok) else fail_stop("Payload byte not taken before the FIFO was full");
        end
        // The 17th byte stalls once the FIFO holds 16
        push_beat(beats[16], 20, ok);
        assert (!ok) else value_error("byte 17 accepted", 0, 1);
        assert (in_ready == 1'b0) else value_error("in_ready", 0, in_ready);
        sink_enable <= 1'b1;
        sink_random <= 1'b1;
        for (int i = 16; i < 20; i++) begin
            push_beat(beats[i], TIMEOUT, ok);
            assert (ok) else fail_stop("Payload byte not taken after out_ready was released");
        end
        in_valid <= 1'b0;
        wait_drained();
        sink_random <= 1'b0;
    endtask

    task automatic test_led();
        logic [7:0] held;
        cur_test = "led";
        for (int i = 0; i < 3; i++) begin
            send_frame(make_hdr(ECHO_PORT, 3 + i), 3 + i);
        end
        wait_drained();
        assert (led == last_echo_byte) else value_error("led", last_echo_byte, led);
        held = last_echo_byte;
        send_frame(make_hdr(16'd53, 6), 6);
        repeat (8) @(posedge clk);
        assert (led == held) else value_error("led after drop", held, led);
    endtask

    initial begin
        rst           = 1'b1;
        in_hdr_valid  = 1'b0;
        in_hdr        = '0;
        in_valid      = 1'b0;
        in_beat       = '0;
        out_hdr_ready = 1'b1;
        out_ready     = 1'b0;
        sink_enable   = 1'b1;
        sink_random   = 1'b0;
        data_lfsr     = 32'hd622_f3a4;
        gap_lfsr      = 32'hd622_f3a4;
        cur_test      = "reset";
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_after_reset();
        test_single_echo();
        test_drop();
        test_back_pressure();
        test_led();
        if (exp_hdr.size() != 0 || exp_beat.size() != 0) begin
            fail_stop("Expected output still queued at the end of the run");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== src.f ====
src/udp_pkg.sv
src/echo_cfg_pkg.sv
src/udp_echo_filter.sv
src/payload_fifo.sv
src/payload_led_latch.sv
src/udp_echo_core.sv
tests/udp_echo_assert.sv
tests/tb_udp_echo_core.sv
